// File: rtl/mem_pkg.sv
/* memory response package
   buffer classes, response field widths and the response word layout */
package mem_pkg;

    // --------------------------------------------------------------------
    // field widths
    // --------------------------------------------------------------------
    localparam int OFFSET_W = 16;
    localparam int SHIFT_W  = 4;
    localparam int FIELD_W  = 32;

    // --------------------------------------------------------------------
    // buffer classes carried by a response
    // --------------------------------------------------------------------
    typedef enum logic [2:0] {
        BUF_INVALID      = 3'd0,
        BUF_CU_SETUP     = 3'd1,
        BUF_ENGINE_SETUP = 3'd2,
        BUF_OTHER        = 3'd3
    } buffer_class_t;

    // one response word as seen by the engine
    typedef struct packed {
        buffer_class_t         buf_class;
        logic [OFFSET_W-1:0]   offset;
        logic [SHIFT_W-1:0]    shift;
        logic [FIELD_W-1:0]    field0;
    } mem_response_t;

    // sequence number of a response word
    function automatic logic [OFFSET_W-1:0] resp_sequence(input mem_response_t r);
        logic [OFFSET_W-1:0] seq;
        seq = r.offset >> r.shift;
        return seq;
    endfunction

    // only the two set-up classes carry engine parameters
    function automatic logic is_setup_class(input buffer_class_t c);
        logic hit;
        hit = (c == BUF_CU_SETUP) || (c == BUF_ENGINE_SETUP);
        return hit;
    endfunction

endpackage : mem_pkg

// File: rtl/engine_pkg.sv
/* engine configuration package
   sequence window, configuration layout and FIFO sizing */
package engine_pkg;

    // --------------------------------------------------------------------
    // sequence window
    // --------------------------------------------------------------------
    // words per configuration set
    localparam int SEQ_W  = 16;

    // --------------------------------------------------------------------
    // configuration layout
    // --------------------------------------------------------------------
    localparam int HOPS_W = 8;

    typedef struct packed {
        logic [HOPS_W-1:0] hops;
    } engine_config_t;

    // --------------------------------------------------------------------
    // FIFO sizing
    // --------------------------------------------------------------------
    // depth must stay a power of two, pointers wrap on their own
    localparam int FIFO_DEPTH  = 32;
    localparam int PROG_THRESH = 24;

    localparam int FIFO_ADDR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W  = FIFO_ADDR_W + 1;

endpackage : engine_pkg

// File: rtl/fifo_rd_if.sv
/* read side of a synchronous FIFO
   pop strobe, empty flag and one-cycle valid with the popped word */
`timescale 1ns/1ns

interface fifo_rd_if #(
    parameter type payload_t = logic
);

    logic     rd_en;
    logic     empty;
    logic     valid;
    payload_t dout;

    // FIFO side
    modport source (
        input  rd_en,
        output empty,
        output valid,
        output dout
    );

    // reader side
    modport sink (
        output rd_en,
        input  empty,
        input  valid,
        input  dout
    );

endinterface : fifo_rd_if

// File: rtl/sync_fifo.sv
/* synchronous FIFO with programmable-full flag
   registered read data, valid one cycle after an accepted pop */
`timescale 1ns/1ns

module sync_fifo
    import engine_pkg::*;
#(
    parameter type payload_t = logic
) (
    input  logic       ap_clk,
    input  logic       rst_n,
    input  logic       wr_en,
    input  payload_t   din,
    output logic       prog_full,
    fifo_rd_if.source  rd
);

    // --------------------------------------------------------------------
    // storage and pointers
    // --------------------------------------------------------------------
    payload_t               mem [FIFO_DEPTH];
    logic [FIFO_ADDR_W-1:0] wr_ptr;
    logic [FIFO_ADDR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0]  count;
    logic                   full;
    logic                   wr_ok;
    logic                   rd_ok;

    assign full      = (count == FIFO_CNT_W'(FIFO_DEPTH));
    assign rd.empty  = (count == '0);
    assign prog_full = (count >= FIFO_CNT_W'(PROG_THRESH));

    // writes into a full FIFO are dropped, pops on empty are ignored
    assign wr_ok = wr_en && !full;
    assign rd_ok = rd.rd_en && !rd.empty;

    always_ff @(posedge ap_clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd.valid <= 1'b0;
        end else begin
            rd.valid <= rd_ok;
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // data path
    always_ff @(posedge ap_clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= din;
        end
        if (rd_ok) begin
            rd.dout <= mem[rd_ptr];
        end
    end

    // --------------------------------------------------------------------
    // checks
    // --------------------------------------------------------------------
    // upstream is expected to respect the fill level
    a_no_write_when_full: assert property (
        @(posedge ap_clk) disable iff (!rst_n) wr_en |-> !full
    ) else $error("sync_fifo write while full, word dropped");

    // valid only ever answers a pop that moved the read pointer
    a_valid_after_read: assert property (
        @(posedge ap_clk) disable iff (!rst_n) rd.valid |-> (rd_ptr == $past(rd_ptr + 1'b1))
    ) else $error("sync_fifo valid without a preceding read");

endmodule : sync_fifo

// File: rtl/setup_response_filter.sv
/* set-up response filter
   captures each response and keeps set-up words inside the engine window */
`timescale 1ns/1ns

module setup_response_filter
    import mem_pkg::*;
    import engine_pkg::*;
#(
    parameter int unsigned WINDOW_BASE = 0
) (
    input  logic          ap_clk,
    input  logic          rst_n,
    input  logic          resp_valid,
    input  mem_response_t resp,
    output logic          push,
    output mem_response_t push_data
);

    // one extra bit so the upper bound never wraps
    localparam logic [OFFSET_W:0] SEQ_LO = (OFFSET_W + 1)'(WINDOW_BASE);
    localparam logic [OFFSET_W:0] SEQ_HI = (OFFSET_W + 1)'(WINDOW_BASE + SEQ_W);

    logic                resp_valid_q;
    mem_response_t       resp_q;
    logic [OFFSET_W-1:0] seq;
    logic                in_window;
    logic                class_hit;

    // --------------------------------------------------------------------
    // response capture
    // --------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (!rst_n) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= resp_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        resp_q <= resp;
    end

    // --------------------------------------------------------------------
    // window and class match
    // --------------------------------------------------------------------
    assign seq       = resp_sequence(resp_q);
    assign in_window = ({1'b0, seq} >= SEQ_LO) && ({1'b0, seq} < SEQ_HI);
    assign class_hit = is_setup_class(resp_q.buf_class);

    assign push      = resp_valid_q && class_hit && in_window;
    assign push_data = resp_q;

endmodule : setup_response_filter

// File: rtl/config_sequencer.sv
/* configuration sequencer
   pops filtered responses, tracks one set and pushes its configuration */
`timescale 1ns/1ns

module config_sequencer
    import mem_pkg::*;
    import engine_pkg::*;
#(
    parameter int unsigned WINDOW_BASE = 0
) (
    input  logic           ap_clk,
    input  logic           rst_n,
    input  logic           engine_run,
    fifo_rd_if.sink        resp_rd,
    input  logic           cfg_prog_full,
    output logic           cfg_push,
    output engine_config_t cfg_data
);

    localparam logic [OFFSET_W-1:0] SEQ_START = OFFSET_W'(WINDOW_BASE);

    // bit n set means n+1 words of the current set have arrived
    logic [SEQ_W-1:0]    tracker;
    logic                closing;
    logic                last_in_flight;
    logic                tracker_idle;
    logic                start_hit;
    mem_response_t       word;
    logic [OFFSET_W-1:0] word_seq;
    engine_config_t      cfg_q;

    assign word         = resp_rd.dout;
    assign word_seq     = resp_sequence(word);
    assign tracker_idle = (tracker == '0);
    assign start_hit    = tracker_idle && (word_seq == SEQ_START);

    // --------------------------------------------------------------------
    // pop control
    // --------------------------------------------------------------------
    // stop once the final word is already on its way
    assign last_in_flight = tracker[SEQ_W-2] && resp_rd.valid;
    assign closing        = tracker[SEQ_W-1] || last_in_flight;

    assign resp_rd.rd_en = !resp_rd.empty && engine_run && !cfg_prog_full && !closing;

    // --------------------------------------------------------------------
    // sequence tracker
    // --------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (!rst_n) begin
            tracker <= '0;
        end else if (tracker[SEQ_W-1]) begin
            // set complete
            tracker <= '0;
        end else if (resp_rd.valid) begin
            if (start_hit) begin
                tracker <= SEQ_W'(1);
            end else begin
                // an idle tracker stays idle, the stray word is dropped
                tracker <= tracker << 1;
            end
        end
    end

    // hops comes from the first word of the set
    always_ff @(posedge ap_clk) begin
        if (resp_rd.valid && start_hit) begin
            cfg_q.hops <= word.field0[HOPS_W-1:0];
        end
    end

    // --------------------------------------------------------------------
    // configuration output
    // --------------------------------------------------------------------
    assign cfg_push = tracker[SEQ_W-1];
    assign cfg_data = cfg_q;

    a_tracker_onehot: assert property (
        @(posedge ap_clk) disable iff (!rst_n) $onehot0(tracker)
    ) else $error("config_sequencer tracker holds more than one bit");

endmodule : config_sequencer

// File: rtl/engine_config_capture.sv
/* engine configuration capture top level
   filter, response FIFO, sequencer and configuration FIFO */
`timescale 1ns/1ns

module engine_config_capture
    import mem_pkg::*;
    import engine_pkg::*;
#(
    parameter int unsigned WINDOW_BASE = 0
) (
    input  logic                ap_clk,
    input  logic                rst_n,
    input  logic                resp_valid,
    input  buffer_class_t       resp_class,
    input  logic [OFFSET_W-1:0] resp_offset,
    input  logic [SHIFT_W-1:0]  resp_shift,
    input  logic [FIELD_W-1:0]  resp_field0,
    input  logic                engine_run,
    input  logic                cfg_rd_en,
    output logic                cfg_valid,
    output logic [HOPS_W-1:0]   cfg_hops,
    output logic                cfg_empty
);

    mem_response_t  resp_word;
    logic           resp_push;
    mem_response_t  resp_push_data;
    logic           cfg_push;
    engine_config_t cfg_data;
    logic           cfg_prog_full;

    fifo_rd_if #(.payload_t(mem_response_t))  resp_rd ();
    fifo_rd_if #(.payload_t(engine_config_t)) cfg_rd ();

    // ---------------------------------------------------------------------
    // input packing
    // ---------------------------------------------------------------------
    assign resp_word.buf_class = resp_class;
    assign resp_word.offset    = resp_offset;
    assign resp_word.shift     = resp_shift;
    assign resp_word.field0    = resp_field0;

    setup_response_filter #(.WINDOW_BASE(WINDOW_BASE)) u_filter (
        .ap_clk    (ap_clk),
        .rst_n     (rst_n),
        .resp_valid(resp_valid),
        .resp      (resp_word),
        .push      (resp_push),
        .push_data (resp_push_data)
    );

    // response fill level is not used for back-pressure
    sync_fifo #(.payload_t(mem_response_t)) u_resp_fifo (
        .ap_clk   (ap_clk),
        .rst_n    (rst_n),
        .wr_en    (resp_push),
        .din      (resp_push_data),
        .prog_full(),
        .rd       (resp_rd.source)
    );

    config_sequencer #(.WINDOW_BASE(WINDOW_BASE)) u_sequencer (
        .ap_clk       (ap_clk),
        .rst_n        (rst_n),
        .engine_run   (engine_run),
        .resp_rd      (resp_rd.sink),
        .cfg_prog_full(cfg_prog_full),
        .cfg_push     (cfg_push),
        .cfg_data     (cfg_data)
    );

    sync_fifo #(.payload_t(engine_config_t)) u_cfg_fifo (
        .ap_clk   (ap_clk),
        .rst_n    (rst_n),
        .wr_en    (cfg_push),
        .din      (cfg_data),
        .prog_full(cfg_prog_full),
        .rd       (cfg_rd.source)
    );

    // ---------------------------------------------------------------------
    // configuration read port
    // ---------------------------------------------------------------------
    assign cfg_rd.rd_en = cfg_rd_en;
    assign cfg_valid    = cfg_rd.valid;
    assign cfg_hops     = cfg_rd.dout.hops;
    assign cfg_empty    = cfg_rd.empty;

endmodule : engine_config_capture

// File: tests/tb_config_checker.sv
/* configuration checker
   compares every cfg_valid with the expected hops queue and counts errors */
`timescale 1ns/1ns

module tb_config_checker
    import engine_pkg::*;
(
    input logic              ap_clk,
    input logic              rst_n,
    input logic              cfg_valid,
    input logic [HOPS_W-1:0] cfg_hops,
    input logic              cfg_empty
);

    logic [HOPS_W-1:0] exp_q [$];
    logic [HOPS_W-1:0] exp_hops;
    int                error_count = 0;

    task automatic expect_hops(input logic [HOPS_W-1:0] hops);
        exp_q.push_back(hops);
    endtask

    // configurations still due
    function automatic int pending();
        return exp_q.size();
    endfunction

    task automatic check_level(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("error at %0t ns: %s = %b, expected %b", $time, name, actual, expected);
            error_count++;
        end
    endtask

    // nothing stored and nothing being read
    task automatic check_idle();
        check_level("cfg_valid", cfg_valid, 1'b0);
        check_level("cfg_empty", cfg_empty, 1'b1);
    endtask

    // ----------------------------------------------------------------------
    // configuration read-out
    // ----------------------------------------------------------------------
    always @(posedge ap_clk) begin
        if (rst_n && cfg_valid) begin
            if (exp_q.size() == 0) begin
                $display("configuration with hops 0x%02h at %0t ns was not expected",
                         cfg_hops, $time);
                error_count++;
            end else begin
                exp_hops = exp_q.pop_front();
                if (cfg_hops !== exp_hops) begin
                    $display("error at %0t ns: cfg_hops = 0x%02h, expected 0x%02h",
                             $time, cfg_hops, exp_hops);
                    error_count++;
                end
            end
        end
    end

endmodule : tb_config_checker

// File: tests/tb_engine_config_capture.sv
/* engine configuration capture testbench
   response sets from a table applied in a loop, results checked by the checker */
`timescale 1ns/1ns

module tb_engine_config_capture
    import mem_pkg::*;
    import engine_pkg::*;
();

    localparam int WINDOW_BASE = 32;
    localparam int NUM_TESTS   = 5;
    localparam int MAX_WAIT    = 1000;

    // one response word and the control levels that go with it
    typedef struct {
        int                  test;
        buffer_class_t       cls;
        logic [OFFSET_W-1:0] offset;
        logic [SHIFT_W-1:0]  shift;
        logic [FIELD_W-1:0]  field0;
        logic                run;
    } stim_row_t;

    logic                ap_clk;
    logic                rst_n;
    logic                resp_valid;
    buffer_class_t       resp_class;
    logic [OFFSET_W-1:0] resp_offset;
    logic [SHIFT_W-1:0]  resp_shift;
    logic [FIELD_W-1:0]  resp_field0;
    logic                engine_run;
    logic                cfg_rd_en;
    logic                cfg_valid;
    logic [HOPS_W-1:0]   cfg_hops;
    logic                cfg_empty;

    stim_row_t         rows [$];
    int                exp_test [$];
    logic [HOPS_W-1:0] exp_hops [$];
    string             test_name [NUM_TESTS] = '{"reset state", "single set",
                                                 "filtered noise", "stray words",
                                                 "back-pressure"};
    logic [31:0]       lfsr_state = 32'hc2a34d22;
    logic              held;
    int                errors_before;
    int                passed = 0;
    int                failed = 0;

    engine_config_capture #(.WINDOW_BASE(WINDOW_BASE)) u_engine_config_capture (
        .ap_clk     (ap_clk),
        .rst_n      (rst_n),
        .resp_valid (resp_valid),
        .resp_class (resp_class),
        .resp_offset(resp_offset),
        .resp_shift (resp_shift),
        .resp_field0(resp_field0),
        .engine_run (engine_run),
        .cfg_rd_en  (cfg_rd_en),
        .cfg_valid  (cfg_valid),
        .cfg_hops   (cfg_hops),
        .cfg_empty  (cfg_empty)
    );

    tb_config_checker u_checker (
        .ap_clk   (ap_clk),
        .rst_n    (rst_n),
        .cfg_valid(cfg_valid),
        .cfg_hops (cfg_hops),
        .cfg_empty(cfg_empty)
    );

    initial begin
        ap_clk = 1'b0;
        forever #10 ap_clk = ~ap_clk;
    end

    // ----------------------------------------------------------------------
    // stimulus table
    // ----------------------------------------------------------------------
    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic add_row(input int test, input buffer_class_t cls, input int seq,
                           input int shift, input logic run);
        stim_row_t r;
        r.test   = test;
        r.cls    = cls;
        r.shift  = SHIFT_W'(shift);
        // bits below the shift amount must not move the sequence
        r.offset = OFFSET_W'((seq << shift) | int'(take_bits(shift)));
        r.field0 = take_bits(FIELD_W);
        r.run    = run;
        rows.push_back(r);
    endtask

    task automatic add_set(input int test, input int shift, input logic run);
        int first;
        first = rows.size();
        for (int i = 0; i < SEQ_W; i++) begin
            add_row(test, (i % 2 == 0) ? BUF_ENGINE_SETUP : BUF_CU_SETUP,
                    WINDOW_BASE + i, shift, run);
        end
        // hops from the word at the window base
        exp_test.push_back(test);
        exp_hops.push_back(rows[first].field0[HOPS_W-1:0]);
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t ns while waiting for %s", $time, what);
        $display("TESTS FAILED");
        $finish;
    endtask

    task automatic wait_cfg_stored();
        int cycles;
        cycles = 0;
        while (cfg_empty) begin
            if (cycles == MAX_WAIT)
                report_timeout("a configuration to be stored");
            @(negedge ap_clk);
            cycles++;
        end
    endtask

    task automatic wait_cfg_read();
        int cycles;
        cycles = 0;
        while (u_checker.pending() != 0) begin
            if (cycles == MAX_WAIT)
                report_timeout("the expected configurations to be read");
            @(negedge ap_clk);
            cycles++;
        end
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        rst_n       = 1'b0;
        resp_valid  = 1'b0;
        resp_class  = BUF_INVALID;
        resp_offset = '0;
        resp_shift  = '0;
        resp_field0 = '0;
        engine_run  = 1'b0;
        cfg_rd_en   = 1'b0;

        add_set(1, 0, 1'b1);
        // wrong class inside the window, right class outside it
        // engine held so any noise let through would crowd the set out of the response FIFO
        for (int i = 0; i <= FIFO_DEPTH - SEQ_W; i++) begin
            add_row(2, BUF_OTHER, WINDOW_BASE + i, 1, 1'b0);
            add_row(2, BUF_ENGINE_SETUP, WINDOW_BASE + SEQ_W + i, 1, 1'b0);
            add_row(2, BUF_CU_SETUP, WINDOW_BASE - 1 - i, 0, 1'b0);
        end
        add_set(2, 1, 1'b0);
        for (int i = 0; i < 3; i++) begin
            add_row(3, BUF_CU_SETUP, WINDOW_BASE + 3 + 6 * i, 1 + i, 1'b1);
        end
        add_set(3, 3, 1'b1);
        add_set(4, 2, 1'b0);
        add_set(4, 0, 1'b0);

        repeat (4) @(posedge ap_clk);
        rst_n <= 1'b1;

        for (int t = 0; t < NUM_TESTS; t++) begin
            errors_before = u_checker.error_count;
            held = 1'b0;
            @(negedge ap_clk);
            u_checker.check_idle();
            foreach (exp_test[k]) begin
                if (exp_test[k] == t)
                    u_checker.expect_hops(exp_hops[k]);
            end
            foreach (rows[k]) begin
                if (rows[k].test == t) begin
                    @(posedge ap_clk);
                    resp_valid  <= 1'b1;
                    resp_class  <= rows[k].cls;
                    resp_offset <= rows[k].offset;
                    resp_shift  <= rows[k].shift;
                    resp_field0 <= rows[k].field0;
                    engine_run  <= rows[k].run;
                    cfg_rd_en   <= rows[k].run;
                    held = held | !rows[k].run;
                end
            end
            @(posedge ap_clk);
            resp_valid <= 1'b0;
            if (held) begin
                // engine stopped, so nothing may reach the config FIFO
                repeat (20) begin
                    @(negedge ap_clk);
                    u_checker.check_level("cfg_empty", cfg_empty, 1'b1);
                end
                @(posedge ap_clk);
                engine_run <= 1'b1;
                wait_cfg_stored();
            end
            @(posedge ap_clk);
            engine_run <= 1'b1;
            cfg_rd_en  <= 1'b1;
            wait_cfg_read();
            if (u_checker.error_count == errors_before) begin
                passed++;
                $display("test %0d %s: pass", t, test_name[t]);
            end else begin
                failed++;
                $display("test %0d %s: fail with %0d errors", t, test_name[t],
                         u_checker.error_count - errors_before);
            end
        end

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 NUM_TESTS, passed, failed, u_checker.error_count);
        if (failed == 0 && u_checker.error_count == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule : tb_engine_config_capture

// File: build.f
rtl/mem_pkg.sv
rtl/engine_pkg.sv
rtl/fifo_rd_if.sv
rtl/sync_fifo.sv
rtl/setup_response_filter.sv
rtl/config_sequencer.sv
rtl/engine_config_capture.sv
tests/tb_config_checker.sv
tests/tb_engine_config_capture.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the engine configuration capture testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f \
    --top-module tb_engine_config_capture -o sim_tb
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
